// ==== Makefile ====
# Verilator run of the EAE testbench; exit status is the test result

sim:
	verilator --binary --timing --assert --top-module eae_unit_tb -f eae_unit.f
	./obj_dir/Veae_unit_tb

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== eae_unit.f ====
+incdir+rtl
+incdir+test
rtl/eae_pkg.sv
rtl/eae_setup.sv
rtl/eae_job_fifo.sv
rtl/eae_engine.sv
rtl/eae_unit.sv
test/eae_unit_tb.sv

// ==== rtl/eae_engine.sv ====
// ==========================================================================
// One iteration step per clock: 12 for MUL and DIV, one per place for the
// shifts. The result stays on res_* until res_ready; no pop meanwhile.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "eae_settings.svh"

module eae_engine
(
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             q_valid,
    input  wire eae_pkg::eae_op_t q_op,
    input  wire eae_pkg::word_t   q_ac,
    input  wire eae_pkg::word_t   q_mq,
    input  wire eae_pkg::word_t   q_operand,
    input  wire logic             q_link,
    input  wire eae_pkg::sc_t     q_count,
    input  wire logic             q_done,
    input  wire logic             res_ready,
    output logic                  q_ready,
    output logic                  res_valid,
    output eae_pkg::word_t        res_ac,
    output eae_pkg::word_t        res_mq,
    output logic                  res_link
);
    import eae_pkg::*;

    engine_state_t          state;
    eae_op_t                op_r;
    word_t                  operand_r;
    sc_t                    step_r;
    logic [`EAE_WORD_W:0]   mul_sum;   // carry out of AC
    logic [`EAE_WORD_W+1:0] div_diff;  // top bit is the borrow

    // pop only in IDLE with a job waiting
    assign q_ready   = (state == ST_IDLE) && q_valid;
    assign res_valid = state == ST_DONE;

    // multiplier bit comes out of MQ bit 0
    assign mul_sum = {1'b0, res_ac} + (res_mq[0] ? {1'b0, operand_r} : '0);

    // trial subtract of the divisor from AC with the next MQ bit shifted in
    assign div_diff = {1'b0, res_ac, res_mq[`EAE_WORD_W-1]} - {2'b00, operand_r};

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= ST_IDLE;
        else
        begin
            case (state)
                ST_IDLE:
                    if (q_ready)
                        state <= q_done ? ST_DONE : ST_ITERATE;
                ST_ITERATE:
                    if (step_r == sc_t'(1))
                        state <= ST_DONE;  // last step this cycle
                ST_DONE:
                    if (res_ready)
                        state <= ST_IDLE;
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (q_ready)
        begin
            op_r      <= q_op;
            operand_r <= q_operand;
            step_r    <= q_count;
            res_ac    <= q_ac;
            res_mq    <= q_mq;
            res_link  <= q_link;
        end
        else if (state == ST_ITERATE)
        begin
            step_r <= step_r - sc_t'(1);
            case (op_r)
                OP_MUL:  // add if MQ bit set, then shift AC:MQ right
                    {res_ac, res_mq} <= {mul_sum, res_mq[`EAE_WORD_W-1:1]};
                OP_DIV:
                    if (!div_diff[`EAE_WORD_W+1])
                    begin
                        res_ac <= div_diff[`EAE_WORD_W-1:0];
                        res_mq <= {res_mq[`EAE_WORD_W-2:0], 1'b1};
                    end
                    else
                    begin
                        // restore by keeping the old AC, just shifted
                        res_ac <= {res_ac[`EAE_WORD_W-2:0], res_mq[`EAE_WORD_W-1]};
                        res_mq <= {res_mq[`EAE_WORD_W-2:0], 1'b0};
                    end
                OP_SHL:
                    {res_link, res_ac, res_mq} <= {res_ac, res_mq, 1'b0};
                default:  // ASR and LSR, fill from link
                    {res_ac, res_mq} <= {res_link, res_ac, res_mq[`EAE_WORD_W-1:1]};
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/eae_job_fifo.sv ====
// ==========================================================================
// First-word fall-through job FIFO. Depth must be a power of two; a push
// is taken when full if a pop happens on the same edge.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "eae_settings.svh"

module eae_job_fifo
(
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             job_in_valid,
    input  wire eae_pkg::eae_op_t job_op,
    input  wire eae_pkg::word_t   job_ac,
    input  wire eae_pkg::word_t   job_mq,
    input  wire eae_pkg::word_t   job_operand,
    input  wire logic             job_link,
    input  wire eae_pkg::sc_t     job_count,
    input  wire logic             job_done,
    input  wire logic             q_ready,
    output logic                  job_in_ready,
    output logic                  q_valid,
    output eae_pkg::eae_op_t      q_op,
    output eae_pkg::word_t        q_ac,
    output eae_pkg::word_t        q_mq,
    output eae_pkg::word_t        q_operand,
    output logic                  q_link,
    output eae_pkg::sc_t          q_count,
    output logic                  q_done
);
    import eae_pkg::*;

    localparam int DEPTH = `EAE_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int OP_W  = $bits(eae_op_t);
    localparam int W     = $bits(word_t);
    localparam int SC_W  = $bits(sc_t);
    localparam int JOB_W = OP_W + 3 * W + SC_W + 2;

    logic [JOB_W-1:0] mem [DEPTH];
    logic [JOB_W-1:0] wr_word;
    logic [JOB_W-1:0] rd_word;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    assign q_valid      = count != '0;
    assign job_in_ready = (count != (PTR_W+1)'(DEPTH)) || q_ready;
    assign push         = job_in_valid && job_in_ready;
    assign pop          = q_valid && q_ready;

    // op | ac | mq | operand | link | count | done
    assign wr_word = {job_op, job_ac, job_mq, job_operand, job_link, job_count, job_done};
    assign rd_word = mem[rd_ptr];

    assign q_done    = rd_word[0];
    assign q_count   = rd_word[SC_W:1];
    assign q_link    = rd_word[SC_W+1];
    assign q_operand = rd_word[SC_W+1+W -: W];
    assign q_mq      = rd_word[SC_W+1+2*W -: W];
    assign q_ac      = rd_word[SC_W+1+3*W -: W];
    assign q_op      = eae_op_t'(rd_word[JOB_W-1 -: OP_W]);

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= wr_word;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + PTR_W'(1);  // wraps at DEPTH
            if (pop)
                rd_ptr <= rd_ptr + PTR_W'(1);
            case ({push, pop})
                2'b10:   count <= count + (PTR_W+1)'(1);
                2'b01:   count <= count - (PTR_W+1)'(1);
                default: ;  // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/eae_pkg.sv ====
// ==========================================================================
// Types shared by the EAE blocks. Widths come from eae_settings.svh.
// ==========================================================================
`default_nettype none

`include "eae_settings.svh"

package eae_pkg;

    // one machine word (AC, MQ, operand)
    typedef logic [`EAE_WORD_W-1:0] word_t;

    // step counter and shift count
    typedef logic [`EAE_SC_W-1:0] sc_t;

    // mode-A operations kept in this unit
    typedef enum logic [2:0]
    {
        OP_MUL = 3'd0,  // AC:MQ = AC + MQ * operand
        OP_DIV = 3'd1,  // restoring divide of AC:MQ
        OP_SHL = 3'd2,  // link:AC:MQ left, zero fill
        OP_ASR = 3'd3,  // AC:MQ right, sign fill
        OP_LSR = 3'd4   // AC:MQ right, zero fill
    } eae_op_t;

    // iteration engine
    typedef enum logic [1:0]
    {
        ST_IDLE    = 2'd0,  // waiting for a job
        ST_ITERATE = 2'd1,  // one step per clock
        ST_DONE    = 2'd2   // result held until taken
    } engine_state_t;

endpackage

`default_nettype wire

// ==== rtl/eae_settings.svh ====
// ==========================================================================
// Sizing for the mode-A EAE. EAE_FIFO_DEPTH must be a power of two.
// ==========================================================================
`ifndef EAE_SETTINGS_SVH
`define EAE_SETTINGS_SVH

// machine word, used for AC, MQ and the memory operand
`define EAE_WORD_W      12

// step counter, also holds a shift count of up to 31
`define EAE_SC_W        5

// job slots between setup and engine
`define EAE_FIFO_DEPTH  4

// operand shift field at or above this saturates the result
`define EAE_MAX_SHIFT   24

`endif

// ==== rtl/eae_setup.sv ====
// ==========================================================================
// Mode A only. Shift count is operand[4:0] + 1; DIV overflow and saturated
// shifts are finished here and leave with job_done set.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "eae_settings.svh"

module eae_setup
(
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             cmd_valid,
    input  wire eae_pkg::eae_op_t cmd_op,
    input  wire eae_pkg::word_t   cmd_ac,
    input  wire eae_pkg::word_t   cmd_mq,
    input  wire eae_pkg::word_t   cmd_operand,
    input  wire logic             job_in_ready,
    output logic                  cmd_ready,
    output logic                  job_in_valid,
    output eae_pkg::eae_op_t      job_op,
    output eae_pkg::word_t        job_ac,
    output eae_pkg::word_t        job_mq,
    output eae_pkg::word_t        job_operand,
    output logic                  job_link,
    output eae_pkg::sc_t          job_count,
    output logic                  job_done
);
    import eae_pkg::*;

    sc_t   shift_field;
    sc_t   shift_count;
    logic  shift_sat;
    logic  div_ovf;
    logic  sign;
    logic  accept;

    word_t nx_ac;
    word_t nx_mq;
    logic  nx_link;
    sc_t   nx_count;
    logic  nx_done;

    assign shift_field = cmd_operand[`EAE_SC_W-1:0];
    assign shift_count = shift_field + sc_t'(1);                 // n = field + 1
    assign shift_sat   = shift_field >= sc_t'(`EAE_MAX_SHIFT);
    assign div_ovf     = cmd_ac >= cmd_operand;                  // quotient won't fit
    assign sign        = cmd_ac[`EAE_WORD_W-1];

    // holding register empty, or emptying on this edge
    assign cmd_ready = !job_in_valid || job_in_ready;
    assign accept    = cmd_valid && cmd_ready;

    always_comb
    begin
        nx_ac    = cmd_ac;
        nx_mq    = cmd_mq;
        nx_link  = 1'b0;
        nx_count = sc_t'(`EAE_WORD_W);  // MUL and DIV take one step per bit
        nx_done  = 1'b0;
        case (cmd_op)
            OP_DIV:
                if (div_ovf)
                begin
                    nx_mq   = {cmd_mq[`EAE_WORD_W-2:0], 1'b1};
                    nx_link = 1'b1;
                    nx_done = 1'b1;
                end
            OP_SHL, OP_LSR:
            begin
                nx_count = shift_count;
                if (shift_sat)
                begin
                    nx_ac   = '0;  // everything shifted out
                    nx_mq   = '0;
                    nx_done = 1'b1;
                end
            end
            OP_ASR:
            begin
                nx_count = shift_count;
                nx_link  = sign;  // link doubles as the fill bit
                if (shift_sat)
                begin
                    nx_ac   = {`EAE_WORD_W{sign}};
                    nx_mq   = {`EAE_WORD_W{sign}};
                    nx_done = 1'b1;
                end
            end
            default: ;  // MUL starts with link 0
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            job_in_valid <= 1'b0;
        else if (accept)
            job_in_valid <= 1'b1;
        else if (job_in_ready)
            job_in_valid <= 1'b0;  // FIFO took it
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            job_op      <= cmd_op;
            job_ac      <= nx_ac;
            job_mq      <= nx_mq;
            job_operand <= cmd_operand;
            job_link    <= nx_link;
            job_count   <= nx_count;
            job_done    <= nx_done;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/eae_unit.sv ====
// ==========================================================================
// EAE coprocessor top. Results return in command order; up to
// EAE_FIFO_DEPTH + 2 operations in flight.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module eae_unit
(
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             cmd_valid,
    input  wire eae_pkg::eae_op_t cmd_op,
    input  wire eae_pkg::word_t   cmd_ac,
    input  wire eae_pkg::word_t   cmd_mq,
    input  wire eae_pkg::word_t   cmd_operand,
    output logic                  cmd_ready,
    input  wire logic             res_ready,
    output logic                  res_valid,
    output eae_pkg::word_t        res_ac,
    output eae_pkg::word_t        res_mq,
    output logic                  res_link
);
    import eae_pkg::*;

    // setup to FIFO
    logic    job_in_valid;
    logic    job_in_ready;
    eae_op_t job_op;
    word_t   job_ac;
    word_t   job_mq;
    word_t   job_operand;
    logic    job_link;
    sc_t     job_count;
    logic    job_done;

    // FIFO to engine
    logic    q_valid;
    logic    q_ready;
    eae_op_t q_op;
    word_t   q_ac;
    word_t   q_mq;
    word_t   q_operand;
    logic    q_link;
    sc_t     q_count;
    logic    q_done;

    eae_setup setup_inst
    (
        .clk          (clk),
        .reset        (reset),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_ac       (cmd_ac),
        .cmd_mq       (cmd_mq),
        .cmd_operand  (cmd_operand),
        .job_in_ready (job_in_ready),
        .cmd_ready    (cmd_ready),
        .job_in_valid (job_in_valid),
        .job_op       (job_op),
        .job_ac       (job_ac),
        .job_mq       (job_mq),
        .job_operand  (job_operand),
        .job_link     (job_link),
        .job_count    (job_count),
        .job_done     (job_done)
    );

    eae_job_fifo fifo_inst
    (
        .clk          (clk),
        .reset        (reset),
        .job_in_valid (job_in_valid),
        .job_op       (job_op),
        .job_ac       (job_ac),
        .job_mq       (job_mq),
        .job_operand  (job_operand),
        .job_link     (job_link),
        .job_count    (job_count),
        .job_done     (job_done),
        .q_ready      (q_ready),
        .job_in_ready (job_in_ready),
        .q_valid      (q_valid),
        .q_op         (q_op),
        .q_ac         (q_ac),
        .q_mq         (q_mq),
        .q_operand    (q_operand),
        .q_link       (q_link),
        .q_count      (q_count),
        .q_done       (q_done)
    );

    eae_engine engine_inst
    (
        .clk       (clk),
        .reset     (reset),
        .q_valid   (q_valid),
        .q_op      (q_op),
        .q_ac      (q_ac),
        .q_mq      (q_mq),
        .q_operand (q_operand),
        .q_link    (q_link),
        .q_count   (q_count),
        .q_done    (q_done),
        .res_ready (res_ready),
        .q_ready   (q_ready),
        .res_valid (res_valid),
        .res_ac    (res_ac),
        .res_mq    (res_mq),
        .res_link  (res_link)
    );

endmodule

`default_nettype wire

// ==== test/eae_ref.svh ====
// ==========================================================================
// Expected-result model, included in the testbench after the eae_pkg import.
// Results pack as {link, ac, mq}.
// ==========================================================================
`ifndef EAE_REF_SVH
`define EAE_REF_SVH

typedef logic [2*`EAE_WORD_W-1:0] dword_t;   // AC:MQ
typedef logic [2*`EAE_WORD_W:0]   result_t;  // link:AC:MQ

function automatic result_t mul_add_value(input word_t ac, input word_t mq,
                                          input word_t operand);
    dword_t acc;
    acc = dword_t'(ac) + dword_t'(mq) * dword_t'(operand);  // fits in 24 bits
    return {1'b0, acc};
endfunction

function automatic result_t divide_value(input word_t ac, input word_t mq,
                                         input word_t operand);
    dword_t dividend;
    dword_t quot;
    dword_t rem;
    if (ac >= operand)
        return {1'b1, ac, mq[`EAE_WORD_W-2:0], 1'b1};  // overflow, AC kept
    dividend = {ac, mq};
    quot     = dividend / dword_t'(operand);
    rem      = dividend % dword_t'(operand);
    return {1'b0, rem[`EAE_WORD_W-1:0], quot[`EAE_WORD_W-1:0]};
endfunction

function automatic result_t shifted_value(input eae_op_t op, input word_t ac,
                                          input word_t mq, input word_t operand);
    int      field;
    int      n;
    logic    sign;
    dword_t  pair;
    result_t wide;
    field = int'(operand[`EAE_SC_W-1:0]);
    n     = field + 1;
    sign  = ac[`EAE_WORD_W-1];
    pair  = {ac, mq};
    wide  = {1'b0, ac, mq};
    if (op == OP_SHL)
        return (field >= `EAE_MAX_SHIFT) ? '0 : wide << n;
    if (op == OP_LSR)
        return (field >= `EAE_MAX_SHIFT) ? '0 : {1'b0, pair >> n};
    // ASR, link takes the sign
    if (field >= `EAE_MAX_SHIFT)
        return {(2*`EAE_WORD_W+1){sign}};
    return {sign, dword_t'($signed(pair) >>> n)};
endfunction

function automatic result_t predict_result(input eae_op_t op, input word_t ac,
                                           input word_t mq, input word_t operand);
    case (op)
        OP_MUL:  return mul_add_value(ac, mq, operand);
        OP_DIV:  return divide_value(ac, mq, operand);
        default: return shifted_value(op, ac, mq, operand);
    endcase
endfunction

`endif

// ==== test/eae_unit_tb.sv ====
// ==========================================================================
// Random mode-A commands under long res_ready stalls. Results are checked
// in command order against eae_ref.svh at the result handshake.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "eae_settings.svh"

module eae_unit_tb;
    import eae_pkg::*;

    `include "eae_ref.svh"

    localparam int W          = `EAE_WORD_W;
    localparam int NUM_CMDS   = 300;
    localparam int MAX_CYCLES = NUM_CMDS * 30 * 3;  // worst latency plus stall margin
    localparam int WORD_SPAN  = 1 << `EAE_WORD_W;

    logic    clk         = 1'b0;
    logic    reset       = 1'b1;
    logic    cmd_valid   = 1'b0;
    eae_op_t cmd_op      = OP_MUL;
    word_t   cmd_ac      = '0;
    word_t   cmd_mq      = '0;
    word_t   cmd_operand = '0;
    logic    res_ready   = 1'b0;
    logic    cmd_ready;
    logic    res_valid;
    word_t   res_ac;
    word_t   res_mq;
    logic    res_link;

    result_t expected_q[$];
    int      sent       = 0;
    int      received   = 0;
    int      cycles     = 0;
    int      stall_left = 0;
    logic    held_valid = 1'b0;  // result waited last cycle
    result_t held_data  = '0;
    logic    saw_full   = 1'b0;  // cmd_ready seen low
    logic    reset_seen = 1'b0;  // reset applied at an earlier edge

    eae_unit eae_unit_inst
    (
        .clk         (clk),
        .reset       (reset),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_ac      (cmd_ac),
        .cmd_mq      (cmd_mq),
        .cmd_operand (cmd_operand),
        .cmd_ready   (cmd_ready),
        .res_ready   (res_ready),
        .res_valid   (res_valid),
        .res_ac      (res_ac),
        .res_mq      (res_mq),
        .res_link    (res_link)
    );

    always #20 clk = ~clk;

    task automatic report_mismatch(input string name, input result_t expected,
                                   input result_t actual);
        $display("[FAIL] %s expected 0x%0h got 0x%0h", name, expected, actual);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_error(input string what);
        $display("ERROR: %s", what);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic make_command();
        int      pick;
        int      ac;
        int      mq;
        int      operand;
        eae_op_t op;
        pick    = int'($urandom % 5);
        ac      = int'($urandom % WORD_SPAN);
        mq      = int'($urandom % WORD_SPAN);
        operand = int'($urandom % WORD_SPAN);
        case (pick)
            0:       op = OP_MUL;
            1:       op = OP_DIV;
            2:       op = OP_SHL;
            3:       op = OP_ASR;
            default: op = OP_LSR;
        endcase
        if (op == OP_DIV && $urandom % 2 == 0)
        begin
            if (operand == 0)
                operand = 1;
            ac = ac % operand;  // quotient fits
        end
        else if (op == OP_DIV)
            ac = operand + int'($urandom % (WORD_SPAN - operand));  // overflow
        else if (op != OP_MUL && $urandom % 4 == 0)
        begin
            // count field corners 0, 23, 24, 31
            case (2'($urandom))
                2'd0:    operand = operand & ~31;
                2'd1:    operand = (operand & ~31) | 23;
                2'd2:    operand = (operand & ~31) | `EAE_MAX_SHIFT;
                default: operand = operand | 31;
            endcase
        end
        cmd_valid   <= 1'b1;
        cmd_op      <= op;
        cmd_ac      <= word_t'(ac);
        cmd_mq      <= word_t'(mq);
        cmd_operand <= word_t'(operand);
    endtask

    initial
    begin
        logic free;
        void'($urandom(25205));
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        assert (cmd_ready && !res_valid)
            else report_error("cmd_ready low or res_valid high right after reset");
        while (sent < NUM_CMDS)
        begin
            @(posedge clk);
            free = !cmd_valid || cmd_ready;
            if (cmd_valid && cmd_ready)
            begin
                expected_q.push_back(predict_result(cmd_op, cmd_ac, cmd_mq, cmd_operand));
                sent++;
            end
            if (free && sent < NUM_CMDS && $urandom % 4 != 0)
                make_command();
            else if (free)
                cmd_valid <= 1'b0;
        end
        wait (received == NUM_CMDS);
        repeat (30) @(posedge clk);  // longest single operation, a stray result shows
        if (res_valid || !saw_full)
            report_error("extra result after the last command, or cmd_ready never fell");
        else
        begin
            $display("Simulation passed");
            $finish;
        end
    end

    // one long stall right after reset fills the FIFO
    always @(posedge clk)
    begin
        if (reset)
        begin
            res_ready  <= 1'b0;
            stall_left = 40;
        end
        else if (stall_left > 0)
        begin
            res_ready  <= 1'b0;
            stall_left = stall_left - 1;
        end
        else
        begin
            res_ready <= 1'b1;
            if ($urandom % 16 == 0)
                stall_left = 10 + int'($urandom % 31);
        end
    end

    always @(posedge clk)
    begin
        result_t exp;
        if (reset)
        begin
            if (reset_seen)
                assert (!res_valid) else report_error("res_valid high during reset");
            reset_seen = 1'b1;
        end
        else
        begin
            if (held_valid)
            begin
                assert (res_valid) else report_error("res_valid dropped before it was taken");
                assert ({res_link, res_ac, res_mq} == held_data)
                    else report_mismatch("held res_link:res_ac:res_mq", held_data,
                                         {res_link, res_ac, res_mq});
            end
            if (res_valid && res_ready)
            begin
                assert (expected_q.size() != 0)
                    else report_error("result seen with no command outstanding");
                exp = expected_q.pop_front();
                assert (res_ac == exp[2*W-1:W])
                    else report_mismatch("res_ac", result_t'(exp[2*W-1:W]), result_t'(res_ac));
                assert (res_mq == exp[W-1:0])
                    else report_mismatch("res_mq", result_t'(exp[W-1:0]), result_t'(res_mq));
                assert (res_link == exp[2*W])
                    else report_mismatch("res_link", result_t'(exp[2*W]), result_t'(res_link));
                received++;
            end
            held_valid = res_valid && !res_ready;
            held_data  = {res_link, res_ac, res_mq};
            if (!cmd_ready)
                saw_full = 1'b1;
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
            report_error("timed out waiting for results");
    end

endmodule

`default_nettype wire
